// ==== bench/frame_loop_extract_tb.sv ====
// Frame-loop extraction testbench
// Random frames through the extraction block, checked against a model of the
// packing and capture rules

`include "loop_extract_settings.svh"

module frame_loop_extract_tb;
	import loop_extract_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int EXP_DEPTH = 256;
	localparam int BYTES_PER_WORD = `LE_LOG_WIDTH / 8;
	localparam int NO_LIMIT = 1 << 20;
	localparam int MODE_FULL = 0;
	localparam int MODE_SCATTER = 1;
	localparam int MODE_NONE = 2;
	localparam int MODE_RANDOM = 3;
	// Bytes over all frames sent below
	localparam int TOTAL_BYTES = 24 + 16 + 13 + 21 + 10 + 200 + 2 * 9 + 6 * 8 + 2 * 7;
	localparam int WATCHDOG_CYCLES = TOTAL_BYTES * 4 + 2000;

	logic clk = 1'b0;
	logic rst_n;
	logic srst;
	logic enable;
	in_beat_t in_beat;
	logic in_valid;
	timestamp_t current_time;
	log_word_t frame_data;
	logic frame_valid;
	logic frame_ready;
	ctl_rec_t ctl_data;
	logic ctl_valid;
	logic ctl_ready;
	logic [63:0] overflow_count;

	// Expected outputs in arrival order
	log_word_t exp_words [EXP_DEPTH];
	ctl_rec_t exp_recs [EXP_DEPTH];
	int word_wr = 0;
	int word_rd = 0;
	int rec_wr = 0;
	int rec_rd = 0;
	logic [63:0] exp_overflow = '0;

	string test_name = "reset";
	int value_errors = 0;
	int other_errors = 0;

	frame_loop_extract i_frame_loop_extract (
		.clk(clk),
		.rst_n(rst_n),
		.srst(srst),
		.enable(enable),
		.in_beat(in_beat),
		.in_valid(in_valid),
		.current_time(current_time),
		.frame_data(frame_data),
		.frame_valid(frame_valid),
		.frame_ready(frame_ready),
		.ctl_data(ctl_data),
		.ctl_valid(ctl_valid),
		.ctl_ready(ctl_ready),
		.overflow_count(overflow_count)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		#1;
		current_time = current_time + 64'd1;
	end

	// Pop the expected items on each output transfer
	always @(posedge clk) begin
		if (rst_n && frame_valid && frame_ready) begin
			word_rd <= word_rd + 1;
		end
		if (rst_n && ctl_valid && ctl_ready) begin
			rec_rd <= rec_rd + 1;
		end
	end

	a_word_expected: assert property (@(posedge clk) disable iff (!rst_n)
		(frame_valid && frame_ready) |-> word_rd < word_wr)
		else begin
			other_errors++;
			$display("%s: a frame word came out while none was expected", test_name);
		end

	a_word_value: assert property (@(posedge clk) disable iff (!rst_n)
		(frame_valid && frame_ready && word_rd < word_wr) |-> frame_data == exp_words[word_rd])
		else begin
			value_errors++;
			$display("ERROR %s frame word: expected %h actual %h", test_name,
				exp_words[$sampled(word_rd)], $sampled(frame_data));
		end

	a_rec_expected: assert property (@(posedge clk) disable iff (!rst_n)
		(ctl_valid && ctl_ready) |-> rec_rd < rec_wr)
		else begin
			other_errors++;
			$display("%s: a control record came out while none was expected", test_name);
		end

	a_rec_value: assert property (@(posedge clk) disable iff (!rst_n)
		(ctl_valid && ctl_ready && rec_rd < rec_wr) |-> ctl_data == exp_recs[rec_rd])
		else begin
			value_errors++;
			$display("ERROR %s control record: expected %h actual %h", test_name,
				exp_recs[$sampled(rec_rd)], $sampled(ctl_data));
		end

	a_overflow_value: assert property (@(posedge clk) disable iff (!rst_n)
		overflow_count == exp_overflow)
		else begin
			value_errors++;
			$display("ERROR %s overflow count: expected %0d actual %0d", test_name,
				$sampled(exp_overflow), $sampled(overflow_count));
		end

	function automatic in_beat_t make_beat(input bit ext, input bit last);
		in_beat_t b;
		int pick;
		b.data = byte_t'($urandom);
		b.last = last;
		b.fcs_invalid = 1'b0;
		for (int s = 0; s < `LE_NUM_SCRIPTS; s++) begin
			b.flags[s].matched = 1'($urandom_range(1));
			if (ext) begin
				b.flags[s].extract_req = 1'($urandom_range(1));
			end else begin
				b.flags[s].extract_req = !b.flags[s].matched && ($urandom_range(1) == 1);
			end
		end
		// At least one script wants this byte
		if (ext) begin
			pick = $urandom_range(`LE_NUM_SCRIPTS - 1);
			b.flags[pick].matched = 1'b1;
			b.flags[pick].extract_req = 1'b1;
		end
		return b;
	endfunction

	function automatic bit is_extracted(input in_beat_t b);
		bit hit;
		hit = 1'b0;
		for (int s = 0; s < `LE_NUM_SCRIPTS; s++) begin
			hit |= b.flags[s].matched & b.flags[s].extract_req;
		end
		return hit;
	endfunction

	function automatic script_mask_t match_of(input in_beat_t b);
		script_mask_t m;
		for (int s = 0; s < `LE_NUM_SCRIPTS; s++) begin
			m[s] = b.flags[s].matched;
		end
		return m;
	endfunction

	// room is how many words the frame FIFO takes before it stalls
	task automatic send_frame(input int len, input int mode, input bit captured,
		input int room);
		in_beat_t frame [$];
		timestamp_t t_beat [$];
		log_word_t word;
		ctl_rec_t rec;
		bit ext;
		int n_ext;
		int n_bytes;
		int n_words;
		int trunc_at;
		n_ext = 0;
		for (int i = 0; i < len; i++) begin
			case (mode)
				MODE_FULL: ext = 1'b1;
				MODE_NONE: ext = 1'b0;
				default: ext = ($urandom_range(2) == 0);
			endcase
			// Odd count ending on an extracted byte
			if (mode == MODE_SCATTER && i == len - 2) begin
				ext = (n_ext % 2 == 1);
			end
			if (mode == MODE_SCATTER && i == len - 1) begin
				ext = 1'b1;
			end
			n_ext += ext;
			frame.push_back(make_beat(ext, i == len - 1));
		end

		word = '0;
		n_bytes = 0;
		n_words = 0;
		trunc_at = -1;
		for (int i = 0; i < len && captured && trunc_at < 0; i++) begin
			if (is_extracted(frame[i])) begin
				word = {word[`LE_LOG_WIDTH-9:0], frame[i].data};
				n_bytes++;
				if (n_bytes % BYTES_PER_WORD == 0 || frame[i].last) begin
					exp_words[word_wr] = word;
					word_wr++;
					n_words++;
					word = '0;
					if (n_words > room) begin
						trunc_at = i;
					end
				end
			end
		end

		for (int i = 0; i <= len; i++) begin
			@(posedge clk);
			if (i > 0) begin
				t_beat.push_back(current_time);
			end
			if (i == len && !(captured && trunc_at < 0)) begin
				exp_overflow = exp_overflow + 64'd1;
			end
			#1;
			if (i < len) begin
				in_beat = frame[i];
				in_valid = 1'b1;
			end else begin
				in_valid = 1'b0;
			end
		end

		if (captured) begin
			rec.length = frame_len_t'(n_bytes);
			if (trunc_at >= 0) begin
				rec.match = '0;
				rec.timestamp = t_beat[trunc_at];
			end else begin
				rec.match = match_of(frame[len-1]);
				rec.timestamp = t_beat[len-1];
			end
			exp_recs[rec_wr] = rec;
			rec_wr++;
		end
		repeat (4) @(posedge clk);
	endtask

	task automatic drain_outputs();
		while (word_rd < word_wr || rec_rd < rec_wr) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
	endtask

	task automatic print_summary();
		$display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		print_summary();
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		void'($urandom(32'h54f98158));
		rst_n = 1'b0;
		srst = 1'b0;
		enable = 1'b0;
		in_beat = '0;
		in_valid = 1'b0;
		current_time = '0;
		frame_ready = 1'b1;
		ctl_ready = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		enable = 1'b1;
		repeat (3) @(posedge clk);

		test_name = "full_extract";
		send_frame(24, MODE_FULL, 1'b1, NO_LIMIT);
		send_frame(16, MODE_FULL, 1'b1, NO_LIMIT);
		drain_outputs();

		test_name = "scattered";
		send_frame(13, MODE_SCATTER, 1'b1, NO_LIMIT);
		send_frame(21, MODE_SCATTER, 1'b1, NO_LIMIT);
		drain_outputs();

		test_name = "no_extract";
		send_frame(10, MODE_NONE, 1'b1, NO_LIMIT);
		drain_outputs();

		// Frame FIFO stalled from empty
		test_name = "frame_fifo_full";
		#1;
		frame_ready = 1'b0;
		send_frame(200, MODE_FULL, 1'b1, `LE_FRAME_FIFO_DEPTH);
		@(posedge clk);
		#1;
		frame_ready = 1'b1;
		drain_outputs();

		test_name = "enable_low";
		#1;
		enable = 1'b0;
		repeat (3) @(posedge clk);
		send_frame(9, MODE_RANDOM, 1'b0, NO_LIMIT);
		send_frame(9, MODE_RANDOM, 1'b0, NO_LIMIT);
		#1;
		enable = 1'b1;
		drain_outputs();

		test_name = "ctl_fifo_full";
		#1;
		ctl_ready = 1'b0;
		for (int f = 0; f < `LE_CTL_FIFO_DEPTH; f++) begin
			send_frame(8, MODE_RANDOM, 1'b1, NO_LIMIT);
		end
		send_frame(8, MODE_RANDOM, 1'b0, NO_LIMIT);
		send_frame(8, MODE_RANDOM, 1'b0, NO_LIMIT);
		#1;
		ctl_ready = 1'b1;
		drain_outputs();

		test_name = "srst_clear";
		#1;
		srst = 1'b1;
		@(posedge clk);
		exp_overflow = '0;
		#1;
		srst = 1'b0;
		enable = 1'b0;
		repeat (3) @(posedge clk);
		send_frame(7, MODE_RANDOM, 1'b0, NO_LIMIT);
		send_frame(7, MODE_RANDOM, 1'b0, NO_LIMIT);
		#1;
		enable = 1'b1;
		drain_outputs();

		test_name = "end";
		repeat (10) @(posedge clk);
		if (word_rd != word_wr || rec_rd != rec_wr || frame_valid || ctl_valid) begin
			other_errors++;
			$display("Outputs left over at the end: %0d words and %0d records unmatched",
				word_wr - word_rd, rec_wr - rec_rd);
		end
		print_summary();
		if (value_errors == 0 && other_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== hw/extract_packer.sv ====
// Extraction packer
// Packs script-extracted bytes into log words and builds one control record per
// frame; frames that cannot be captured in full are counted as overflows

`include "loop_extract_settings.svh"

module extract_packer (
	input logic clk,
	input logic rst_n,
	input logic srst,
	input logic enable,
	input loop_extract_pkg::in_beat_t in_beat,
	input logic in_valid,
	input loop_extract_pkg::timestamp_t current_time,
	output loop_extract_pkg::log_word_t word_data,
	output logic word_valid,
	input logic word_ready,
	output loop_extract_pkg::ctl_rec_t rec_data,
	output logic rec_valid,
	input logic rec_ready,
	output logic [63:0] overflow_count
);
	import loop_extract_pkg::*;

	localparam int BYTES_PER_WORD = `LE_LOG_WIDTH / 8;
	localparam int SLOT_BITS = $clog2(BYTES_PER_WORD);

	packer_state_t state;
	logic in_frame;

	// Up to seven earlier bytes of the current word
	logic [`LE_LOG_WIDTH-9:0] byte_sr;
	frame_len_t count;

	script_mask_t script_match;
	script_mask_t extract_vec;
	logic extract_any;

	logic start_capture;
	logic capture_beat;
	logic take_byte;
	logic need_push;
	logic truncate;
	logic finish;
	logic load_word;
	logic load_rec;
	logic lost_frame;

	log_word_t next_word;
	ctl_rec_t next_rec;
	frame_len_t held_len;

	always_comb begin
		for (int i = 0; i < `LE_NUM_SCRIPTS; i++) begin
			script_match[i] = in_beat.flags[i].matched;
			extract_vec[i] = in_beat.flags[i].matched & in_beat.flags[i].extract_req;
		end
	end

	assign extract_any = |extract_vec;

	// Only between frames, with room on both sides
	assign start_capture = (state == ST_WAIT_FIFO) && enable && !in_frame && !in_valid &&
		word_ready && rec_ready;

	assign capture_beat = (state == ST_WRITE_FRAME) && in_valid;
	assign take_byte = capture_beat && extract_any;
	assign need_push = take_byte &&
		(count[SLOT_BITS-1:0] == '1 || in_beat.last);
	assign truncate = need_push && !word_ready;
	assign finish = capture_beat && in_beat.last && !truncate;

	// A word still waiting keeps its slot, the new one is dropped
	assign load_word = (need_push && word_ready) || (truncate && !word_valid);
	assign load_rec = finish || truncate;

	assign lost_frame = in_valid && in_beat.last &&
		((state != ST_WRITE_FRAME) || truncate);

	assign next_word = {byte_sr, in_beat.data};

	// Bytes up to the last word already handed over
	assign held_len = count & ~frame_len_t'(BYTES_PER_WORD - 1);

	always_comb begin
		next_rec.match = script_match;
		next_rec.length = count + frame_len_t'(extract_any);
		next_rec.timestamp = current_time;
		if (truncate) begin
			next_rec.match = '0;
			next_rec.length = word_valid ? held_len : count + 1'b1;
		end
	end

	// Payload path
	always_ff @(posedge clk) begin
		if (start_capture) begin
			count <= '0;
			byte_sr <= '0;
		end else if (take_byte) begin
			count <= count + 1'b1;
			if (need_push) begin
				byte_sr <= '0;
			end else begin
				byte_sr <= {byte_sr[`LE_LOG_WIDTH-17:0], in_beat.data};
			end
		end

		if (load_word) begin
			word_data <= next_word;
		end
		if (load_rec) begin
			rec_data <= next_rec;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_WAIT_FIFO;
			in_frame <= 1'b0;
			word_valid <= 1'b0;
			rec_valid <= 1'b0;
			overflow_count <= '0;
		end else begin
			if (in_valid) begin
				in_frame <= !in_beat.last;
			end

			if (word_valid && word_ready) begin
				word_valid <= 1'b0;
			end
			if (rec_valid && rec_ready) begin
				rec_valid <= 1'b0;
			end
			if (load_word) begin
				word_valid <= 1'b1;
			end

			case (state)
				ST_WAIT_FIFO: begin
					if (start_capture) begin
						state <= ST_WRITE_FRAME;
					end
				end

				ST_WRITE_FRAME: begin
					if (truncate) begin
						state <= ST_OVERFLOW;
					end else if (finish) begin
						state <= ST_WRITE_CTL;
						rec_valid <= 1'b1;
					end else if (!in_valid && !in_frame && !enable) begin
						state <= ST_WAIT_FIFO;
					end
				end

				ST_WRITE_CTL: begin
					if (rec_valid && rec_ready) begin
						state <= ST_WAIT_FIFO;
					end
				end

				ST_OVERFLOW: begin
					// Record follows once the held word is gone
					if (word_valid && word_ready) begin
						state <= ST_WAIT_FIFO;
						rec_valid <= 1'b1;
					end
				end

				default: begin
					state <= ST_WAIT_FIFO;
				end
			endcase

			if (srst) begin
				overflow_count <= '0;
			end else if (lost_frame) begin
				overflow_count <= overflow_count + 64'd1;
			end
		end
	end

	a_word_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(word_valid && !word_ready) |=> word_valid && $stable(word_data))
		else $error("extract_packer: word dropped or changed before transfer");

	// A frame that starts after enable was low is never captured
	a_enable_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(in_valid && !in_frame && !$past(enable)) |-> state != ST_WRITE_FRAME)
		else $error("extract_packer: capturing while disabled between frames");

endmodule

// ==== hw/frame_loop_extract.sv ====
// Frame-loop extraction top level
// Packer feeding a frame word FIFO and a control record FIFO

`include "loop_extract_settings.svh"

module frame_loop_extract (
	input logic clk,
	input logic rst_n,
	input logic srst,
	input logic enable,
	input loop_extract_pkg::in_beat_t in_beat,
	input logic in_valid,
	input loop_extract_pkg::timestamp_t current_time,
	output loop_extract_pkg::log_word_t frame_data,
	output logic frame_valid,
	input logic frame_ready,
	output loop_extract_pkg::ctl_rec_t ctl_data,
	output logic ctl_valid,
	input logic ctl_ready,
	output logic [63:0] overflow_count
);
	import loop_extract_pkg::*;

	log_word_t word_data;
	logic word_valid;
	logic word_ready;

	ctl_rec_t rec_data;
	logic rec_valid;
	logic rec_ready;

	extract_packer i_packer (
		.clk(clk),
		.rst_n(rst_n),
		.srst(srst),
		.enable(enable),
		.in_beat(in_beat),
		.in_valid(in_valid),
		.current_time(current_time),
		.word_data(word_data),
		.word_valid(word_valid),
		.word_ready(word_ready),
		.rec_data(rec_data),
		.rec_valid(rec_valid),
		.rec_ready(rec_ready),
		.overflow_count(overflow_count)
	);

	stream_fifo #(
		.DEPTH(`LE_FRAME_FIFO_DEPTH),
		.ITEM_T(log_word_t)
	) i_frame_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.push_data(word_data),
		.push_valid(word_valid),
		.push_ready(word_ready),
		.pop_data(frame_data),
		.pop_valid(frame_valid),
		.pop_ready(frame_ready)
	);

	stream_fifo #(
		.DEPTH(`LE_CTL_FIFO_DEPTH),
		.ITEM_T(ctl_rec_t)
	) i_ctl_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.push_data(rec_data),
		.push_valid(rec_valid),
		.push_ready(rec_ready),
		.pop_data(ctl_data),
		.pop_valid(ctl_valid),
		.pop_ready(ctl_ready)
	);

endmodule

// ==== hw/loop_extract_pkg.sv ====
// Frame-loop extraction types
// Widths, the per-byte input beat, the control record and the packer states

`include "loop_extract_settings.svh"

package loop_extract_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [`LE_LOG_WIDTH-1:0] log_word_t;
	typedef logic [`LE_NUM_SCRIPTS-1:0] script_mask_t;
	typedef logic [15:0] frame_len_t;
	typedef logic [63:0] timestamp_t;

	// Extract only when both bits are set
	typedef struct packed {
		logic matched;
		logic extract_req;
	} script_flags_t;

	// One frame byte with its sideband
	typedef struct packed {
		byte_t data;
		logic last;
		logic fcs_invalid;
		script_flags_t [`LE_NUM_SCRIPTS-1:0] flags;
	} in_beat_t;

	// End-of-frame record, 84 bits with four scripts
	typedef struct packed {
		script_mask_t match;
		frame_len_t length;
		timestamp_t timestamp;
	} ctl_rec_t;

	typedef enum logic [1:0] {
		ST_WAIT_FIFO,
		ST_WRITE_FRAME,
		ST_WRITE_CTL,
		ST_OVERFLOW
	} packer_state_t;

endpackage

// ==== hw/loop_extract_settings.svh ====
// Frame-loop extraction settings
// Script count, log word width and FIFO depths shared by the extraction block

`ifndef LOOP_EXTRACT_SETTINGS_SVH
`define LOOP_EXTRACT_SETTINGS_SVH

// Scripts reported by the upstream script engine
`define LE_NUM_SCRIPTS 4

// Frame word width in bits, a whole number of bytes
`define LE_LOG_WIDTH 64

// Frame FIFO depth in words
`define LE_FRAME_FIFO_DEPTH 16

// Control FIFO depth in records
`define LE_CTL_FIFO_DEPTH 4

`endif

// ==== hw/stream_fifo.sv ====
// Synchronous stream FIFO
// Circular buffer with valid/ready on both sides, item type and depth as parameters

module stream_fifo #(
	parameter int DEPTH = 4,
	parameter type ITEM_T = logic
) (
	input logic clk,
	input logic rst_n,
	input ITEM_T push_data,
	input logic push_valid,
	output logic push_ready,
	output ITEM_T pop_data,
	output logic pop_valid,
	input logic pop_ready
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	ITEM_T mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push_fire;
	logic pop_fire;

	assign push_ready = (count != CNT_W'(DEPTH));
	assign pop_valid = (count != '0);
	assign pop_data = mem[rd_ptr];

	assign push_fire = push_valid && push_ready;
	assign pop_fire = pop_valid && pop_ready;

	always_ff @(posedge clk) begin
		if (push_fire) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push_fire) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop_fire) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push_fire, pop_fire})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Writer holds its item while the FIFO is full
	a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
		(push_valid && !push_ready) |=> push_valid && $stable(push_data))
		else $error("stream_fifo: write dropped or changed while full");

	// Count agrees with the pointer distance
	a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
		count <= CNT_W'(DEPTH) &&
		(int'(wr_ptr) - int'(rd_ptr) + DEPTH) % DEPTH == int'(count) % DEPTH)
		else $error("stream_fifo: count beyond depth or out of step with pointers");

endmodule

// ==== tb.f ====
+incdir+hw
hw/loop_extract_pkg.sv
hw/stream_fifo.sv
hw/extract_packer.sv
hw/frame_loop_extract.sv
bench/frame_loop_extract_tb.sv
